// ==== filelist.f ====
hdl/soc_pkg.sv
hdl/mem_router.sv
hdl/sram_port.sv
hdl/sys_regs.sv
hdl/pad_mux.sv
hdl/irq_route.sv
hdl/soc_fabric_top.sv
test/tb_soc_fabric.sv

// ==== hdl/irq_route.sv ====
`timescale 1ns/10ps

module irq_route (
  input  soc_pkg::route_cfg_t  route_cfg_i,
  input  soc_pkg::gpio_t       gpio_in_i,
  input  logic                 irq_pin_i,
  input  logic                 irq_spi_i,
  output soc_pkg::irq_vec_t    irq_o
);
  import soc_pkg::*;

  logic irq7;
  logic irq8;

  // select 1..3 picks src bit 0..2, select 0 is off
  function automatic logic pick_src(sel2_t sel, logic [2:0] src);
    logic res;
    case (sel)
      2'd1:    res = src[0];
      2'd2:    res = src[1];
      2'd3:    res = src[2];
      default: res = 1'b0;
    endcase
    return res;
  endfunction

  assign irq7 = pick_src(route_cfg_i.irq7_src, gpio_in_i[2:0]);
  assign irq8 = pick_src(route_cfg_i.irq8_src, gpio_in_i[5:3]);

  always_comb begin
    irq_o                = '0;
    irq_o[IRQ_PIN_BIT]   = irq_pin_i;
    irq_o[IRQ_SPI_BIT]   = irq_spi_i;
    irq_o[IRQ_GPIO7_BIT] = irq7;
    irq_o[IRQ_GPIO8_BIT] = irq8;
  end

endmodule

// ==== hdl/mem_router.sv ====
`timescale 1ns/10ps

module mem_router (
  input  soc_pkg::mem_req_t mem_req_i,
  input  logic              ram_ready_i,
  input  soc_pkg::data_t    ram_rdata_i,
  input  logic              reg_ready_i,
  input  soc_pkg::data_t    reg_rdata_i,
  output logic              ram_sel_o,
  output logic              reg_sel_o,
  output logic              mem_ready_o,
  output soc_pkg::data_t    mem_rdata_o
);
  import soc_pkg::*;

  logic in_ram;
  logic in_page;

  // region decode
  assign in_ram  = mem_req_i.addr < RAM_BYTES;
  assign in_page = mem_req_i.addr[31:8] == SYSREG_PAGE;

  assign ram_sel_o = mem_req_i.valid && in_ram;
  assign reg_sel_o = mem_req_i.valid && in_page;

  // unmapped addresses never see ready
  assign mem_ready_o = ram_ready_i || reg_ready_i;

  always_comb begin
    if (reg_ready_i) begin
      mem_rdata_o = reg_rdata_i;
    end else if (ram_ready_i) begin
      mem_rdata_o = ram_rdata_i;
    end else begin
      mem_rdata_o = '0;
    end
  end

endmodule

// ==== hdl/pad_mux.sv ====
`timescale 1ns/10ps

module pad_mux (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  soc_pkg::gpio_cfg_t   gpio_cfg_i,
  input  soc_pkg::route_cfg_t  route_cfg_i,
  input  logic                 xtal_in_i,
  input  logic                 clk_pll_i,
  input  logic                 trap_i,
  output soc_pkg::gpio_t       gpio_out_o,
  output soc_pkg::gpio_t       gpio_outenb_o,
  output soc_pkg::gpio_t       gpio_pullupb_o,
  output soc_pkg::gpio_t       gpio_pulldownb_o
);
  import soc_pkg::*;

  gpio_t force_mask;
  gpio_t pad_out;

  // put sig on pad base+dest, dest 0 leaves the pads alone
  function automatic gpio_t route_onto(gpio_t pads, sel2_t dest, int unsigned base,
                                       logic sig);
    gpio_t res;
    res = pads;
    if (dest != 2'd0) begin
      res[base + dest] = sig;
    end
    return res;
  endfunction

  // groups: xtal pads 5-7, pll pads 8-10, trap pads 11-13
  always_comb begin
    force_mask = '0;
    if (route_cfg_i.xtal_dest != 2'd0) begin
      force_mask = force_mask | 16'h00e0;
    end
    if (route_cfg_i.pll_dest != 2'd0) begin
      force_mask = force_mask | 16'h0700;
    end
    if (route_cfg_i.trap_dest != 2'd0) begin
      force_mask = force_mask | 16'h3800;
    end
  end

  always_comb begin
    pad_out = route_onto(gpio_cfg_i.out, route_cfg_i.xtal_dest, 4, xtal_in_i);
    pad_out = route_onto(pad_out, route_cfg_i.trap_dest, 10, trap_i);
    // pll group carries two different clocks
    if (route_cfg_i.pll_dest == 2'd1) begin
      pad_out[8] = clk_pll_i;
    end else if (route_cfg_i.pll_dest == 2'd2) begin
      pad_out[9] = clk_i;
    end
  end

  assign gpio_out_o = pad_out;

  // pads float while in reset
  assign gpio_outenb_o    = (gpio_cfg_i.oeb & ~force_mask) | {16{~rst_n_i}};
  assign gpio_pullupb_o   = gpio_cfg_i.pu | force_mask;
  assign gpio_pulldownb_o = gpio_cfg_i.pd | force_mask;

endmodule

// ==== hdl/soc_fabric_top.sv ====
`timescale 1ns/10ps

module soc_fabric_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  soc_pkg::mem_req_t    mem_req_i,
  input  soc_pkg::data_t       ram_rdata_i,
  input  soc_pkg::gpio_t       gpio_in_i,
  input  soc_pkg::hk_status_t  hk_status_i,
  input  logic                 xtal_in_i,
  input  logic                 clk_pll_i,
  input  logic                 trap_i,
  input  logic                 irq_pin_i,
  input  logic                 irq_spi_i,
  output logic                 mem_ready_o,
  output soc_pkg::data_t       mem_rdata_o,
  output soc_pkg::strb_t       ram_wstrb_o,
  output soc_pkg::ram_addr_t   ram_addr_o,
  output soc_pkg::data_t       ram_wdata_o,
  output soc_pkg::gpio_t       gpio_out_o,
  output soc_pkg::gpio_t       gpio_outenb_o,
  output soc_pkg::gpio_t       gpio_pullupb_o,
  output soc_pkg::gpio_t       gpio_pulldownb_o,
  output soc_pkg::irq_vec_t    irq_o
);

  logic                ram_sel;
  logic                reg_sel;
  logic                ram_ready;
  logic                reg_ready;
  soc_pkg::data_t      reg_rdata;
  soc_pkg::gpio_cfg_t  gpio_cfg;
  soc_pkg::route_cfg_t route_cfg;

  mem_router u_mem_router (
    .mem_req_i   (mem_req_i),
    .ram_ready_i (ram_ready),
    .ram_rdata_i (ram_rdata_i),
    .reg_ready_i (reg_ready),
    .reg_rdata_i (reg_rdata),
    .ram_sel_o   (ram_sel),
    .reg_sel_o   (reg_sel),
    .mem_ready_o (mem_ready_o),
    .mem_rdata_o (mem_rdata_o)
  );

  sram_port u_sram_port (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .sel_i       (ram_sel),
    .mem_req_i   (mem_req_i),
    .ready_o     (ram_ready),
    .ram_wstrb_o (ram_wstrb_o),
    .ram_addr_o  (ram_addr_o),
    .ram_wdata_o (ram_wdata_o)
  );

  sys_regs u_sys_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .sel_i       (reg_sel),
    .mem_req_i   (mem_req_i),
    .gpio_in_i   (gpio_in_i),
    .gpio_out_i  (gpio_out_o),
    .hk_status_i (hk_status_i),
    .ready_o     (reg_ready),
    .rdata_o     (reg_rdata),
    .gpio_cfg_o  (gpio_cfg),
    .route_cfg_o (route_cfg)
  );

  pad_mux u_pad_mux (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .gpio_cfg_i       (gpio_cfg),
    .route_cfg_i      (route_cfg),
    .xtal_in_i        (xtal_in_i),
    .clk_pll_i        (clk_pll_i),
    .trap_i           (trap_i),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o)
  );

  irq_route u_irq_route (
    .route_cfg_i (route_cfg),
    .gpio_in_i   (gpio_in_i),
    .irq_pin_i   (irq_pin_i),
    .irq_spi_i   (irq_spi_i),
    .irq_o       (irq_o)
  );

endmodule

// ==== hdl/soc_pkg.sv ====
package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [14:0] ram_addr_t;
  typedef logic [15:0] gpio_t;
  typedef logic [1:0]  sel2_t;
  typedef logic [31:0] irq_vec_t;

  // external sram size and region decode
  localparam int unsigned MEM_WORDS   = 32768;
  localparam addr_t       RAM_BYTES   = 4 * MEM_WORDS;
  localparam logic [23:0] SYSREG_PAGE = 24'h030000;

  // system register page offsets
  localparam logic [7:0] REG_GPIO        = 8'h00;
  localparam logic [7:0] REG_GPIO_OEB    = 8'h04;
  localparam logic [7:0] REG_GPIO_PU     = 8'h08;
  localparam logic [7:0] REG_GPIO_PD     = 8'h0c;
  localparam logic [7:0] REG_HK_CONFIG   = 8'h18;
  localparam logic [7:0] REG_HK_ENA      = 8'h1c;
  localparam logic [7:0] REG_HK_PLL      = 8'h20;
  localparam logic [7:0] REG_HK_MFGR     = 8'h24;
  localparam logic [7:0] REG_HK_PROD     = 8'h28;
  localparam logic [7:0] REG_HK_MASKREV  = 8'h2c;
  localparam logic [7:0] REG_CLK_EXT_SEL = 8'h30;
  localparam logic [7:0] REG_XTAL_DEST   = 8'h34;
  localparam logic [7:0] REG_PLL_DEST    = 8'h38;
  localparam logic [7:0] REG_TRAP_DEST   = 8'h3c;
  localparam logic [7:0] REG_IRQ7_SRC    = 8'h40;
  localparam logic [7:0] REG_IRQ8_SRC    = 8'h44;

  localparam gpio_t GPIO_RESET_OEB = 16'hffff;

  // interrupt vector positions
  localparam int unsigned IRQ_PIN_BIT   = 5;
  localparam int unsigned IRQ_SPI_BIT   = 6;
  localparam int unsigned IRQ_GPIO7_BIT = 7;
  localparam int unsigned IRQ_GPIO8_BIT = 8;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } mem_req_t;

  typedef struct packed {
    gpio_t out;
    gpio_t oeb;
    gpio_t pu;
    gpio_t pd;
  } gpio_cfg_t;

  typedef struct packed {
    sel2_t xtal_dest;
    sel2_t pll_dest;
    sel2_t trap_dest;
    sel2_t irq7_src;
    sel2_t irq8_src;
  } route_cfg_t;

  // housekeeping spi read-only fields
  typedef struct packed {
    logic [7:0]  cfg;
    logic        xtal_ena;
    logic        reg_ena;
    logic        pll_cp_ena;
    logic        pll_vco_ena;
    logic        pll_bias_ena;
    logic [3:0]  pll_trim;
    logic [11:0] mfgr_id;
    logic [7:0]  prod_id;
    logic [3:0]  mask_rev;
    logic        clk_ext_sel;
  } hk_status_t;

endpackage

// ==== hdl/sram_port.sv ====
`timescale 1ns/10ps

module sram_port (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                sel_i,
  input  soc_pkg::mem_req_t   mem_req_i,
  output logic                ready_o,
  output soc_pkg::strb_t      ram_wstrb_o,
  output soc_pkg::ram_addr_t  ram_addr_o,
  output soc_pkg::data_t      ram_wdata_o
);
  import soc_pkg::*;

  logic ready_q;
  logic access;

  // first cycle of a selected request only
  assign access = sel_i && !ready_q;

  assign ram_wstrb_o = access ? mem_req_i.wstrb : strb_t'(0);
  assign ram_addr_o  = mem_req_i.addr[16:2];
  assign ram_wdata_o = mem_req_i.wdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  assign ready_o = ready_q;

endmodule

// ==== hdl/sys_regs.sv ====
`timescale 1ns/10ps

module sys_regs (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 sel_i,
  input  soc_pkg::mem_req_t    mem_req_i,
  input  soc_pkg::gpio_t       gpio_in_i,
  input  soc_pkg::gpio_t       gpio_out_i,
  input  soc_pkg::hk_status_t  hk_status_i,
  output logic                 ready_o,
  output soc_pkg::data_t       rdata_o,
  output soc_pkg::gpio_cfg_t   gpio_cfg_o,
  output soc_pkg::route_cfg_t  route_cfg_o
);
  import soc_pkg::*;

  logic       ready_q;
  logic       access;
  logic       lane0_wr;
  logic [7:0] offset;
  data_t      rdata_q;
  data_t      rdata_next;
  gpio_cfg_t  gpio_q;
  route_cfg_t route_q;

  // gpio registers take byte lanes 0 and 1 only
  function automatic gpio_t lane_merge(gpio_t cur, data_t wdata, strb_t wstrb);
    gpio_t res;
    res = cur;
    if (wstrb[0]) begin
      res[7:0] = wdata[7:0];
    end
    if (wstrb[1]) begin
      res[15:8] = wdata[15:8];
    end
    return res;
  endfunction

  assign access   = sel_i && !ready_q;
  assign lane0_wr = mem_req_i.wstrb[0];
  assign offset   = mem_req_i.addr[7:0];

  always_comb begin
    case (offset)
      REG_GPIO:        rdata_next = {gpio_out_i, gpio_in_i};
      REG_GPIO_OEB:    rdata_next = {16'd0, gpio_q.oeb};
      REG_GPIO_PU:     rdata_next = {16'd0, gpio_q.pu};
      REG_GPIO_PD:     rdata_next = {16'd0, gpio_q.pd};
      REG_HK_CONFIG:   rdata_next = {24'd0, hk_status_i.cfg};
      REG_HK_ENA:      rdata_next = {30'd0, hk_status_i.xtal_ena, hk_status_i.reg_ena};
      REG_HK_PLL: begin
        rdata_next = {25'd0, hk_status_i.pll_trim, hk_status_i.pll_cp_ena,
                      hk_status_i.pll_vco_ena, hk_status_i.pll_bias_ena};
      end
      REG_HK_MFGR:     rdata_next = {20'd0, hk_status_i.mfgr_id};
      REG_HK_PROD:     rdata_next = {24'd0, hk_status_i.prod_id};
      REG_HK_MASKREV:  rdata_next = {28'd0, hk_status_i.mask_rev};
      REG_CLK_EXT_SEL: rdata_next = {31'd0, hk_status_i.clk_ext_sel};
      REG_XTAL_DEST:   rdata_next = {30'd0, route_q.xtal_dest};
      REG_PLL_DEST:    rdata_next = {30'd0, route_q.pll_dest};
      REG_TRAP_DEST:   rdata_next = {30'd0, route_q.trap_dest};
      REG_IRQ7_SRC:    rdata_next = {30'd0, route_q.irq7_src};
      REG_IRQ8_SRC:    rdata_next = {30'd0, route_q.irq8_src};
      default:         rdata_next = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
      gpio_q  <= '{out: '0, oeb: GPIO_RESET_OEB, pu: '0, pd: '0};
      route_q <= '0;
    end else begin
      ready_q <= access;
      if (access) begin
        case (offset)
          REG_GPIO: begin
            gpio_q.out <= lane_merge(gpio_q.out, mem_req_i.wdata, mem_req_i.wstrb);
          end
          REG_GPIO_OEB: begin
            gpio_q.oeb <= lane_merge(gpio_q.oeb, mem_req_i.wdata, mem_req_i.wstrb);
          end
          REG_GPIO_PU: begin
            gpio_q.pu <= lane_merge(gpio_q.pu, mem_req_i.wdata, mem_req_i.wstrb);
          end
          REG_GPIO_PD: begin
            gpio_q.pd <= lane_merge(gpio_q.pd, mem_req_i.wdata, mem_req_i.wstrb);
          end
          // route selects, bits 1:0 on a lane 0 write
          REG_XTAL_DEST: if (lane0_wr) route_q.xtal_dest <= mem_req_i.wdata[1:0];
          REG_PLL_DEST:  if (lane0_wr) route_q.pll_dest <= mem_req_i.wdata[1:0];
          REG_TRAP_DEST: if (lane0_wr) route_q.trap_dest <= mem_req_i.wdata[1:0];
          REG_IRQ7_SRC:  if (lane0_wr) route_q.irq7_src <= mem_req_i.wdata[1:0];
          REG_IRQ8_SRC:  if (lane0_wr) route_q.irq8_src <= mem_req_i.wdata[1:0];
          default: ;
        endcase
      end
    end
  end

  // read data captured with the access, old value for a write
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata_next;
    end
  end

  assign ready_o     = ready_q;
  assign rdata_o     = rdata_q;
  assign gpio_cfg_o  = gpio_q;
  assign route_cfg_o = route_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
  --top-module tb_soc_fabric -f filelist.f \
  --Mdir obj_dir -o tb_soc_fabric

./obj_dir/tb_soc_fabric | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== test/tb_soc_fabric.sv ====
`timescale 1ns/10ps

module tb_soc_fabric;
  import soc_pkg::*;

  // traffic is about 500 cycles, limit leaves a wide margin
  localparam int MAX_CYCLES = 4000;

  logic       clk;
  logic       rst_n;
  mem_req_t   mem_req;
  data_t      ram_rdata;
  gpio_t      gpio_in;
  hk_status_t hk_status;
  logic       xtal_in;
  logic       clk_pll;
  logic       trap;
  logic       irq_pin;
  logic       irq_spi;
  logic       mem_ready;
  data_t      mem_rdata;
  strb_t      ram_wstrb;
  ram_addr_t  ram_addr;
  data_t      ram_wdata;
  gpio_t      pad_out;
  gpio_t      pad_oeb;
  gpio_t      pad_pub;
  gpio_t      pad_pdb;
  irq_vec_t   irq;

  data_t      sram [MEM_WORDS];
  data_t      model_mem [MEM_WORDS];
  gpio_cfg_t  model_gpio;
  route_cfg_t model_route;
  integer     seed = 32'h4772715a;
  int         errors;
  int         checks;
  int         cycle_count;
  logic       watch_en;

  soc_fabric_top u_dut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .mem_req_i        (mem_req),
    .ram_rdata_i      (ram_rdata),
    .gpio_in_i        (gpio_in),
    .hk_status_i      (hk_status),
    .xtal_in_i        (xtal_in),
    .clk_pll_i        (clk_pll),
    .trap_i           (trap),
    .irq_pin_i        (irq_pin),
    .irq_spi_i        (irq_spi),
    .mem_ready_o      (mem_ready),
    .mem_rdata_o      (mem_rdata),
    .ram_wstrb_o      (ram_wstrb),
    .ram_addr_o       (ram_addr),
    .ram_wdata_o      (ram_wdata),
    .gpio_out_o       (pad_out),
    .gpio_outenb_o    (pad_oeb),
    .gpio_pullupb_o   (pad_pub),
    .gpio_pulldownb_o (pad_pdb),
    .irq_o            (irq)
  );

  always #5 clk = ~clk;

  // external sram, byte writes on the strobes
  assign ram_rdata = sram[ram_addr];

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (ram_wstrb[b]) begin
        sram[ram_addr][8*b +: 8] = ram_wdata[8*b +: 8];
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic data_t fill_word(int unsigned idx);
    return {idx[14:0], 2'b01, idx[14:0]};
  endfunction

  function automatic gpio_t set_pad(gpio_t v, int unsigned pos, logic b);
    gpio_t m;
    m = gpio_t'(1) << pos;
    return b ? (v | m) : (v & ~m);
  endfunction

  function automatic logic pad_bit(gpio_t v, int unsigned pos);
    gpio_t s;
    s = v >> pos;
    return s[0];
  endfunction

  function automatic gpio_t merge_lanes(gpio_t cur, data_t d, strb_t s);
    gpio_t res;
    res = cur;
    if (s[0]) begin
      res[7:0] = d[7:0];
    end
    if (s[1]) begin
      res[15:8] = d[15:8];
    end
    return res;
  endfunction

  // pad values as {out, oeb, pu, pd}
  function automatic gpio_cfg_t expected_pads(gpio_cfg_t g, route_cfg_t r, logic xtal,
                                              logic pll, logic clk_lvl, logic trp);
    gpio_cfg_t p;
    gpio_t m;
    m = '0;
    p = g;
    if (r.xtal_dest != 2'd0) begin
      m[7:5] = 3'b111;
      p.out = set_pad(p.out, 4 + r.xtal_dest, xtal);
    end
    if (r.pll_dest != 2'd0) begin
      m[10:8] = 3'b111;
    end
    if (r.pll_dest == 2'd1) begin
      p.out[8] = pll;
    end else if (r.pll_dest == 2'd2) begin
      p.out[9] = clk_lvl;
    end
    if (r.trap_dest != 2'd0) begin
      m[13:11] = 3'b111;
      p.out = set_pad(p.out, 10 + r.trap_dest, trp);
    end
    p.oeb = g.oeb & ~m;
    p.pu  = g.pu | m;
    p.pd  = g.pd | m;
    return p;
  endfunction

  function automatic irq_vec_t expected_irq(route_cfg_t r, gpio_t gin, logic pin, logic spi);
    irq_vec_t v;
    v = '0;
    v[IRQ_PIN_BIT] = pin;
    v[IRQ_SPI_BIT] = spi;
    if (r.irq7_src != 2'd0) begin
      v[IRQ_GPIO7_BIT] = pad_bit(gin, r.irq7_src - 1);
    end
    if (r.irq8_src != 2'd0) begin
      v[IRQ_GPIO8_BIT] = pad_bit(gin, r.irq8_src + 2);
    end
    return v;
  endfunction

  function automatic data_t expected_rdata(logic [7:0] off);
    gpio_cfg_t pads;
    data_t res;
    pads = expected_pads(model_gpio, model_route, xtal_in, clk_pll, clk, trap);
    case (off)
      REG_GPIO:        res = {pads.out, gpio_in};
      REG_GPIO_OEB:    res = {16'd0, model_gpio.oeb};
      REG_GPIO_PU:     res = {16'd0, model_gpio.pu};
      REG_GPIO_PD:     res = {16'd0, model_gpio.pd};
      REG_HK_CONFIG:   res = {24'd0, hk_status.cfg};
      REG_HK_ENA:      res = {30'd0, hk_status.xtal_ena, hk_status.reg_ena};
      REG_HK_PLL: begin
        res = {25'd0, hk_status.pll_trim, hk_status.pll_cp_ena,
               hk_status.pll_vco_ena, hk_status.pll_bias_ena};
      end
      REG_HK_MFGR:     res = {20'd0, hk_status.mfgr_id};
      REG_HK_PROD:     res = {24'd0, hk_status.prod_id};
      REG_HK_MASKREV:  res = {28'd0, hk_status.mask_rev};
      REG_CLK_EXT_SEL: res = {31'd0, hk_status.clk_ext_sel};
      REG_XTAL_DEST:   res = {30'd0, model_route.xtal_dest};
      REG_PLL_DEST:    res = {30'd0, model_route.pll_dest};
      REG_TRAP_DEST:   res = {30'd0, model_route.trap_dest};
      REG_IRQ7_SRC:    res = {30'd0, model_route.irq7_src};
      REG_IRQ8_SRC:    res = {30'd0, model_route.irq8_src};
      default:         res = '0;
    endcase
    return res;
  endfunction

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t: %s, got %h expected %h", $time, msg, actual, expected);
    end
  endtask

  task automatic bus_access(input addr_t addr, input data_t wdata, input strb_t wstrb,
                            output data_t rdata);
    int waits;
    @(posedge clk);
    #1;
    mem_req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
    waits = 0;
    do begin
      @(posedge clk);
      #1;
      waits++;
    end while (!mem_ready);
    rdata = mem_rdata;
    mem_req.valid = 1'b0;
    check_equal(64'(waits), 64'd1, $sformatf("ready delay at %h", addr));
  endtask

  task automatic reg_write(input logic [7:0] off, input data_t wdata, input strb_t wstrb);
    data_t rd;
    bus_access({SYSREG_PAGE, off}, wdata, wstrb, rd);
    case (off)
      REG_GPIO:      model_gpio.out = merge_lanes(model_gpio.out, wdata, wstrb);
      REG_GPIO_OEB:  model_gpio.oeb = merge_lanes(model_gpio.oeb, wdata, wstrb);
      REG_GPIO_PU:   model_gpio.pu = merge_lanes(model_gpio.pu, wdata, wstrb);
      REG_GPIO_PD:   model_gpio.pd = merge_lanes(model_gpio.pd, wdata, wstrb);
      REG_XTAL_DEST: if (wstrb[0]) model_route.xtal_dest = wdata[1:0];
      REG_PLL_DEST:  if (wstrb[0]) model_route.pll_dest = wdata[1:0];
      REG_TRAP_DEST: if (wstrb[0]) model_route.trap_dest = wdata[1:0];
      REG_IRQ7_SRC:  if (wstrb[0]) model_route.irq7_src = wdata[1:0];
      REG_IRQ8_SRC:  if (wstrb[0]) model_route.irq8_src = wdata[1:0];
      default: ;
    endcase
  endtask

  task automatic reg_read(input logic [7:0] off, input string name);
    data_t exp;
    data_t rd;
    exp = expected_rdata(off);
    bus_access({SYSREG_PAGE, off}, '0, '0, rd);
    check_equal(64'(rd), 64'(exp), $sformatf("%s at offset %h", name, off));
  endtask

  task automatic check_idle_outputs(input string when);
    check_equal({pad_out, pad_oeb, pad_pub, pad_pdb}, {16'h0, 16'hffff, 16'h0, 16'h0},
                $sformatf("pads %s", when));
    check_equal(64'(mem_ready), 64'd0, $sformatf("mem ready %s", when));
    check_equal(64'(irq), 64'd0, $sformatf("irq vector %s", when));
    check_equal(64'(ram_wstrb), 64'd0, $sformatf("sram strobes %s", when));
  endtask

  task automatic test_done(input string name, input int errs_before);
    $display("%-8s done, %0d errors", name, errors - errs_before);
  endtask

  // pads and irq against the model in both clock phases
  always begin
    @(clk);
    #3;
    if (watch_en) begin
      check_equal({pad_out, pad_oeb, pad_pub, pad_pdb},
                  expected_pads(model_gpio, model_route, xtal_in, clk_pll, clk, trap), "pads");
      check_equal(64'(irq), 64'(expected_irq(model_route, gpio_in, irq_pin, irq_spi)),
                  "irq vector");
    end
  end

  initial begin
    logic [63:0] r64;
    logic [7:0]  off;
    data_t       rd;
    data_t       wd;
    ram_addr_t   idx;
    strb_t       st;
    ram_addr_t   idx_q[$];
    int          n_before;
    clk = 1'b0;
    rst_n = 1'b0;
    mem_req = '0;
    gpio_in = '0;
    hk_status = '0;
    xtal_in = 1'b0;
    clk_pll = 1'b0;
    trap = 1'b0;
    irq_pin = 1'b0;
    irq_spi = 1'b0;
    errors = 0;
    checks = 0;
    cycle_count = 0;
    watch_en = 1'b0;
    model_gpio = '{out: '0, oeb: '1, pu: '0, pd: '0};
    model_route = '0;
    for (int unsigned i = 0; i < MEM_WORDS; i++) begin
      sram[i] = fill_word(i);
      model_mem[i] = fill_word(i);
    end

    n_before = errors;
    repeat (3) @(posedge clk);
    #1;
    check_idle_outputs("in reset");
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_idle_outputs("after reset");
    watch_en = 1'b1;
    test_done("reset", n_before);

    n_before = errors;
    repeat (24) begin
      idx = ram_addr_t'($random(seed));
      wd = $random(seed);
      st = ($random(seed) & 1) ? 4'hf : strb_t'($random(seed));
      bus_access({15'd0, idx, 2'b00}, wd, st, rd);
      for (int b = 0; b < 4; b++) begin
        if (st[b]) begin
          model_mem[idx][8*b +: 8] = wd[8*b +: 8];
        end
      end
      idx_q.push_back(idx);
    end
    // a few untouched words too
    repeat (4) idx_q.push_back(ram_addr_t'($random(seed)));
    foreach (idx_q[i]) begin
      bus_access({15'd0, idx_q[i], 2'b00}, '0, '0, rd);
      check_equal(64'(rd), 64'(model_mem[idx_q[i]]), $sformatf("sram word %h", idx_q[i]));
    end
    test_done("sram", n_before);

    n_before = errors;
    gpio_in = gpio_t'($random(seed));
    for (int r = 0; r < 4; r++) begin
      off = 8'(4 * r);
      repeat (4) begin
        reg_write(off, $random(seed), strb_t'($random(seed)));
        reg_read(off, "gpio register");
      end
    end
    test_done("gpio", n_before);

    n_before = errors;
    r64 = {$random(seed), $random(seed)};
    hk_status = r64[$bits(hk_status_t)-1:0];
    for (int o = 'h18; o <= 'h30; o += 4) begin
      reg_read(8'(o), "status word");
    end
    test_done("status", n_before);

    n_before = errors;
    for (int s7 = 0; s7 < 4; s7++) begin
      for (int s8 = 0; s8 < 4; s8++) begin
        reg_write(REG_IRQ7_SRC, 32'(s7), 4'h1);
        reg_write(REG_IRQ8_SRC, 32'(s8), 4'h1);
        reg_read(REG_IRQ7_SRC, "irq7 select");
        reg_read(REG_IRQ8_SRC, "irq8 select");
        repeat (3) begin
          @(posedge clk);
          #1;
          gpio_in = gpio_t'($random(seed));
          irq_pin = 1'($random(seed));
          irq_spi = 1'($random(seed));
        end
      end
    end
    test_done("irq", n_before);

    n_before = errors;
    for (int g = 0; g < 3; g++) begin
      off = (g == 0) ? REG_XTAL_DEST : ((g == 1) ? REG_PLL_DEST : REG_TRAP_DEST);
      for (int d = 0; d < 4; d++) begin
        reg_write(off, 32'(d), 4'h1);
        reg_read(off, "route select");
        repeat (4) begin
          @(posedge clk);
          #1;
          xtal_in = ~xtal_in;
          trap = ~trap;
          clk_pll = ~clk_pll;
        end
      end
      reg_write(off, 32'd0, 4'h1);
    end
    test_done("routing", n_before);

    watch_en = 1'b0;
    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycle_count);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
